// ==== tb.f ====
common/dp_reconfig_pkg.sv
design/reconfig_channel_ctrl.sv
design/reconfig_slot_arbiter.sv
design/reconfig_engine.sv
design/dp_reconfig_top.sv
testbench/tb_dp_reconfig.sv

// ==== Makefile ====
TOP := tb_dp_reconfig

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): tb.f common/dp_reconfig_pkg.sv design/*.sv testbench/*.sv
	verilator --binary --timing -Wno-fatal -f tb.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASS" sim.log

lint:
	verilator --lint-only -Wall common/dp_reconfig_pkg.sv design/reconfig_channel_ctrl.sv \
		design/reconfig_slot_arbiter.sv design/reconfig_engine.sv design/dp_reconfig_top.sv \
		--top-module dp_reconfig_top

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_dp_reconfig.sv ====
`timescale 1ns/1ps

module tb_dp_reconfig;
	import dp_reconfig_pkg::*;

	// ************************************************************
	// run limits and the stimulus table
	// ************************************************************

	localparam int num_steps = 8;
	localparam int num_fixed = 6;
	// one step never needs more than both busy times plus handshake overhead
	localparam int step_bound = rate_busy_cycles + drive_busy_cycles + 20;
	localparam int cycle_limit = num_steps * step_bound;

	typedef struct {
		logic         trig_rate;
		logic         trig_drive;
		logic         retrig;
		link_rate_t   rate_pl;
		drive_level_t drive_pl;
		link_rate_t   exp_rate;
		drive_level_t exp_drive;
		logic         exp_rate_done;
		logic         exp_drive_done;
	} step_t;

	step_t steps [num_steps];

	logic         clk;
	logic         reset;
	logic         rate_trigger;
	link_rate_t   rate_din;
	logic         drive_trigger;
	drive_level_t drive_din;
	logic         rate_done;
	logic         drive_done;
	link_rate_t   current_rate;
	drive_level_t current_drive;
	logic         engine_busy;

	int errors = 0;
	int cycles = 0;
	int busy_run = 0;

	dp_reconfig_top dut (
		.clk           (clk),
		.reset         (reset),
		.rate_trigger  (rate_trigger),
		.rate_din      (rate_din),
		.drive_trigger (drive_trigger),
		.drive_din     (drive_din),
		.rate_done     (rate_done),
		.drive_done    (drive_done),
		.current_rate  (current_rate),
		.current_drive (current_drive),
		.engine_busy   (engine_busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic link_rate_t make_rate(input logic [1:0] rate, input logic [2:0] lanes);
		link_rate_t w;
		w.rate  = rate;
		w.lanes = lanes;
		return w;
	endfunction

	function automatic drive_level_t make_drive(input logic [1:0] swing, input logic [1:0] pre);
		drive_level_t w;
		w.swing   = swing;
		w.preemph = pre;
		return w;
	endfunction

	task automatic load_step(input int idx, input logic tr, input logic td, input logic rt,
		input link_rate_t rp, input drive_level_t dp, input link_rate_t er,
		input drive_level_t ed, input logic erd, input logic edd);
		steps[idx].trig_rate      = tr;
		steps[idx].trig_drive     = td;
		steps[idx].retrig         = rt;
		steps[idx].rate_pl        = rp;
		steps[idx].drive_pl       = dp;
		steps[idx].exp_rate       = er;
		steps[idx].exp_drive      = ed;
		steps[idx].exp_rate_done  = erd;
		steps[idx].exp_drive_done = edd;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// ************************************************************
	// one table step, from trigger to all named dones high
	// ************************************************************

	task automatic apply_step(input int idx);
		int   waited;
		logic all_done;
		rate_trigger  = steps[idx].trig_rate;
		rate_din      = steps[idx].rate_pl;
		drive_trigger = steps[idx].trig_drive;
		drive_din     = steps[idx].drive_pl;
		@(negedge clk);
		rate_trigger  = 1'b0;
		drive_trigger = 1'b0;
		// a fresh trigger withdraws the done left over from the last operation
		if (steps[idx].trig_rate)
			check_value("rate_done", 32'(rate_done), 32'd0);
		if (steps[idx].trig_drive)
			check_value("drive_done", 32'(drive_done), 32'd0);
		if (steps[idx].retrig)
		begin
			// the second trigger carries the inverted payload and must be dropped
			@(negedge clk);
			rate_trigger  = steps[idx].trig_rate;
			rate_din      = ~steps[idx].rate_pl;
			drive_trigger = steps[idx].trig_drive;
			drive_din     = ~steps[idx].drive_pl;
			@(negedge clk);
			rate_trigger  = 1'b0;
			drive_trigger = 1'b0;
		end
		waited   = 0;
		all_done = (!steps[idx].trig_rate || rate_done) && (!steps[idx].trig_drive || drive_done);
		while (!all_done && waited < step_bound)
		begin
			@(negedge clk);
			waited++;
			all_done = (!steps[idx].trig_rate || rate_done) &&
				(!steps[idx].trig_drive || drive_done);
		end
		if (!all_done)
		begin
			errors++;
			$display("step %0d: done did not rise within %0d cycles", idx, step_bound);
		end
		check_value("current_rate", 32'(current_rate), 32'(steps[idx].exp_rate));
		check_value("current_drive", 32'(current_drive), 32'(steps[idx].exp_drive));
		check_value("rate_done", 32'(rate_done), 32'(steps[idx].exp_rate_done));
		check_value("drive_done", 32'(drive_done), 32'(steps[idx].exp_drive_done));
		check_value("engine_busy", 32'(engine_busy), 32'd0);
	endtask

	// ************************************************************
	// monitors
	// ************************************************************

	// no single busy stretch may outlast the longer of the two operations
	always @(negedge clk)
	begin
		if (!reset && engine_busy)
		begin
			busy_run++;
			if (busy_run == rate_busy_cycles + 1)
			begin
				errors++;
				$display("engine_busy stayed high longer than %0d cycles at %0t",
					rate_busy_cycles, $time);
			end
		end
		else
		begin
			busy_run = 0;
		end
	end

	always @(posedge clk)
	begin
		if (!reset)
		begin
			cycles++;
			if (cycles >= cycle_limit)
			begin
				$display("run stopped after reaching the limit of %0d cycles", cycle_limit);
				$display("errors: %0d", errors);
				$display("TEST FAIL");
				$finish;
			end
		end
	end

	// ************************************************************
	// main sequence
	// ************************************************************

	initial
	begin
		logic [31:0]  r;
		link_rate_t   rp;
		drive_level_t dp;
		logic         tr;
		logic         td;
		r             = $urandom(32'hcceb781b);
		reset         = 1'b1;
		rate_trigger  = 1'b0;
		rate_din      = '0;
		drive_trigger = 1'b0;
		drive_din     = '0;

		// single channels, both at once, ignored retriggers, then a plain retrigger
		load_step(0, 1, 0, 0, make_rate(rate_hbr2, 3'd4), make_drive(2'd0, 2'd0),
			make_rate(rate_hbr2, 3'd4), make_drive(2'd0, 2'd0), 1, 0);
		load_step(1, 0, 1, 0, make_rate(rate_rbr, 3'd1), make_drive(2'd2, 2'd1),
			make_rate(rate_hbr2, 3'd4), make_drive(2'd2, 2'd1), 1, 1);
		load_step(2, 1, 1, 0, make_rate(rate_hbr3, 3'd2), make_drive(2'd3, 2'd0),
			make_rate(rate_hbr3, 3'd2), make_drive(2'd3, 2'd0), 1, 1);
		load_step(3, 1, 0, 1, make_rate(rate_hbr, 3'd1), make_drive(2'd0, 2'd0),
			make_rate(rate_hbr, 3'd1), make_drive(2'd3, 2'd0), 1, 1);
		load_step(4, 0, 1, 1, make_rate(rate_rbr, 3'd1), make_drive(2'd1, 2'd3),
			make_rate(rate_hbr, 3'd1), make_drive(2'd1, 2'd3), 1, 1);
		load_step(5, 1, 0, 0, make_rate(rate_rbr, 3'd2), make_drive(2'd0, 2'd0),
			make_rate(rate_rbr, 3'd2), make_drive(2'd1, 2'd3), 1, 1);

		// spare steps get random payloads, a triggered channel takes its payload
		// and an untriggered one keeps the previous setting and done
		for (int i = num_fixed; i < num_steps; i++)
		begin
			r  = $urandom;
			rp = make_rate(r[1:0], r[4:2]);
			dp = make_drive(r[6:5], r[8:7]);
			tr = r[9];
			td = r[10] | ~r[9];
			load_step(i, tr, td, 0, rp, dp,
				tr ? rp : steps[i-1].exp_rate,
				td ? dp : steps[i-1].exp_drive,
				tr ? 1'b1 : steps[i-1].exp_rate_done,
				td ? 1'b1 : steps[i-1].exp_drive_done);
		end

		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		check_value("rate_done", 32'(rate_done), 32'd0);
		check_value("drive_done", 32'(drive_done), 32'd0);
		check_value("engine_busy", 32'(engine_busy), 32'd0);
		check_value("current_rate", 32'(current_rate), 32'(make_rate(rate_rbr, 3'd1)));
		check_value("current_drive", 32'(current_drive), 32'd0);

		for (int i = 0; i < num_steps; i++)
		begin
			apply_step(i);
		end

		$display("errors: %0d", errors);
		if (errors == 0)
		begin
			$display("TEST PASS");
		end
		else
		begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== design/dp_reconfig_top.sv ====
`timescale 1ns/1ps

module dp_reconfig_top
(
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          rate_trigger,
	input  dp_reconfig_pkg::link_rate_t   rate_din,
	input  logic                          drive_trigger,
	input  dp_reconfig_pkg::drive_level_t drive_din,
	output logic                          rate_done,
	output logic                          drive_done,
	output dp_reconfig_pkg::link_rate_t   current_rate,
	output dp_reconfig_pkg::drive_level_t current_drive,
	output logic                          engine_busy
);
	import dp_reconfig_pkg::*;

	// per-channel handshake vectors, indexed by channel id
	logic [num_channels-1:0] trig_vec;
	logic [num_channels-1:0] req_vec;
	logic [num_channels-1:0] ready_vec;
	logic [num_channels-1:0] ack_vec;
	link_rate_t              rate_payload;
	drive_level_t            drive_payload;
	logic                    eng_req;
	logic                    eng_ack;
	reconfig_word_t          eng_word;

	assign trig_vec[chan_rate]  = rate_trigger;
	assign trig_vec[chan_drive] = drive_trigger;

	// ********************************************************
	// channel sequencers
	// ********************************************************

	reconfig_channel_ctrl #(
		.payload_t (link_rate_t)
	) rate_ctrl (
		.clk     (clk),
		.reset   (reset),
		.trigger (rate_trigger),
		.din     (rate_din),
		.ready   (ready_vec[chan_rate]),
		.ack     (ack_vec[chan_rate]),
		.busy    (engine_busy),
		.dout    (rate_payload),
		.req     (req_vec[chan_rate]),
		.done    (rate_done)
	);

	reconfig_channel_ctrl #(
		.payload_t (drive_level_t)
	) drive_ctrl (
		.clk     (clk),
		.reset   (reset),
		.trigger (drive_trigger),
		.din     (drive_din),
		.ready   (ready_vec[chan_drive]),
		.ack     (ack_vec[chan_drive]),
		.busy    (engine_busy),
		.dout    (drive_payload),
		.req     (req_vec[chan_drive]),
		.done    (drive_done)
	);

	// ********************************************************
	// shared engine and its slot arbiter
	// ********************************************************

	reconfig_slot_arbiter arbiter (
		.clk           (clk),
		.reset         (reset),
		.trigger       (trig_vec),
		.req           (req_vec),
		.rate_payload  (rate_payload),
		.drive_payload (drive_payload),
		.eng_ack       (eng_ack),
		.eng_busy      (engine_busy),
		.ready         (ready_vec),
		.ack           (ack_vec),
		.eng_req       (eng_req),
		.eng_word      (eng_word)
	);

	reconfig_engine engine (
		.clk           (clk),
		.reset         (reset),
		.eng_req       (eng_req),
		.eng_word      (eng_word),
		.eng_ack       (eng_ack),
		.eng_busy      (engine_busy),
		.current_rate  (current_rate),
		.current_drive (current_drive)
	);

endmodule

// ==== design/reconfig_engine.sv ====
`timescale 1ns/1ps

module reconfig_engine
(
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            eng_req,
	input  dp_reconfig_pkg::reconfig_word_t eng_word,
	output logic                            eng_ack,
	output logic                            eng_busy,
	output dp_reconfig_pkg::link_rate_t     current_rate,
	output dp_reconfig_pkg::drive_level_t   current_drive
);
	import dp_reconfig_pkg::*;

	// ********************************************************
	// request capture
	// ********************************************************

	// this stands in for the transceiver reconfiguration controller
	logic                  start;
	logic [busy_cnt_w-1:0] busy_cnt;
	logic [busy_cnt_w-1:0] busy_load;
	reconfig_word_t        word_q;

	// requests are only taken while idle, a held req during busy is ignored
	assign start = eng_req && !eng_busy;

	// link rate changes take longer than drive level changes
	always_comb
	begin
		if (eng_word.chan_id == chan_drive)
		begin
			busy_load = busy_cnt_w'(drive_busy_cycles - 1);
		end
		else
		begin
			busy_load = busy_cnt_w'(rate_busy_cycles - 1);
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			word_q <= eng_word;
		end
	end

	// ********************************************************
	// busy timer and status update
	// ********************************************************

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			eng_ack       <= 1'b0;
			eng_busy      <= 1'b0;
			busy_cnt      <= '0;
			current_rate  <= rate_reset;
			current_drive <= '0;
		end
		else
		begin
			// ack is a single pulse alongside the rise of busy
			eng_ack <= 1'b0;
			if (start)
			begin
				eng_ack  <= 1'b1;
				eng_busy <= 1'b1;
				busy_cnt <= busy_load;
			end
			else if (eng_busy)
			begin
				if (busy_cnt == '0)
				begin
					// settings land in the status registers as busy falls
					eng_busy <= 1'b0;
					if (word_q.chan_id == chan_drive)
					begin
						current_drive <= drive_level_t'(word_q.data[$bits(drive_level_t)-1:0]);
					end
					else
					begin
						current_rate <= link_rate_t'(word_q.data);
					end
				end
				else
				begin
					busy_cnt <= busy_cnt - 1'b1;
				end
			end
		end
	end

endmodule

// ==== design/reconfig_slot_arbiter.sv ====
`timescale 1ns/1ps

module reconfig_slot_arbiter
(
	input  logic                                     clk,
	input  logic                                     reset,
	input  logic [dp_reconfig_pkg::num_channels-1:0] trigger,
	input  logic [dp_reconfig_pkg::num_channels-1:0] req,
	input  dp_reconfig_pkg::link_rate_t              rate_payload,
	input  dp_reconfig_pkg::drive_level_t            drive_payload,
	input  logic                                     eng_ack,
	input  logic                                     eng_busy,
	output logic [dp_reconfig_pkg::num_channels-1:0] ready,
	output logic [dp_reconfig_pkg::num_channels-1:0] ack,
	output logic                                     eng_req,
	output dp_reconfig_pkg::reconfig_word_t          eng_word
);
	import dp_reconfig_pkg::*;

	// pending runs from trigger to ack, in_flight from ack to engine idle
	logic [num_channels-1:0] pending;
	logic [num_channels-1:0] in_flight;
	logic [num_channels-1:0] waiting;
	logic [num_channels-1:0] grant;
	logic [num_channels-1:0] next_grant;
	logic [chan_id_w-1:0]    rr_ptr;
	logic [chan_id_w-1:0]    next_ptr;
	logic [chan_id_w-1:0]    grant_id;

	// ********************************************************
	// round-robin pick
	// ********************************************************

	assign waiting = pending & ~req;

	// scan from the pointer and take the first waiting channel
	always_comb
	begin
		int idx;
		next_grant = '0;
		next_ptr   = rr_ptr;
		for (int i = 0; i < num_channels; i++)
		begin
			idx = (int'(rr_ptr) + i) % num_channels;
			if (waiting[idx] && next_grant == '0)
			begin
				next_grant[idx] = 1'b1;
				next_ptr        = chan_id_w'((idx + 1) % num_channels);
			end
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pending   <= '0;
			in_flight <= '0;
			grant     <= '0;
			rr_ptr    <= '0;
		end
		else
		begin
			for (int i = 0; i < num_channels; i++)
			begin
				// mirror the channel FSM so a trigger it ignores is ignored here too
				if (ack[i])
				begin
					pending[i]   <= 1'b0;
					in_flight[i] <= 1'b1;
				end
				else if (in_flight[i] && !eng_busy)
				begin
					in_flight[i] <= 1'b0;
				end
				else if (trigger[i] && !pending[i] && !in_flight[i])
				begin
					pending[i] <= 1'b1;
				end
			end
			// a new slot only opens once the engine is idle again
			if (eng_ack)
			begin
				grant <= '0;
			end
			else if (grant == '0 && !eng_busy && |waiting)
			begin
				grant  <= next_grant;
				rr_ptr <= next_ptr;
			end
		end
	end

	// ********************************************************
	// steering to and from the engine
	// ********************************************************

	always_comb
	begin
		grant_id = '0;
		for (int i = 0; i < num_channels; i++)
		begin
			if (grant[i])
			begin
				grant_id = chan_id_w'(i);
			end
		end
	end

	assign ready   = grant;
	assign ack     = grant & {num_channels{eng_ack}};
	assign eng_req = |(req & grant);

	always_comb
	begin
		eng_word.chan_id = grant_id;
		if (grant_id == chan_drive)
		begin
			eng_word.data = reconfig_data_w'(drive_payload);
		end
		else
		begin
			eng_word.data = rate_payload;
		end
	end

endmodule

// ==== design/reconfig_channel_ctrl.sv ====
`timescale 1ns/1ps

module reconfig_channel_ctrl
#(
	parameter type payload_t = logic [0:0]
)
(
	input  logic     clk,
	input  logic     reset,
	input  logic     trigger,
	input  payload_t din,
	input  logic     ready,
	input  logic     ack,
	input  logic     busy,
	output payload_t dout,
	output logic     req,
	output logic     done
);

	// ********************************************************
	// request sequencer
	// ********************************************************

	// one pass is trigger, slot, acknowledge, then engine idle
	typedef enum logic [1:0] {
		wait_trigger,
		wait_ready,
		wait_ack,
		wait_busy_low
	} state_t;

	state_t state;

	// the payload is only taken while idle, so a trigger that
	// arrives mid-operation leaves the held settings alone
	always_ff @(posedge clk)
	begin
		if (state == wait_trigger && trigger)
		begin
			dout <= din;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= wait_trigger;
			req   <= 1'b0;
			done  <= 1'b0;
		end
		else
		begin
			case (state)
				wait_trigger:
				begin
					// a new trigger also withdraws the previous done
					if (trigger)
					begin
						done  <= 1'b0;
						state <= wait_ready;
					end
				end
				wait_ready:
				begin
					// the arbiter has handed us the engine slot
					if (ready)
					begin
						req   <= 1'b1;
						state <= wait_ack;
					end
				end
				wait_ack:
				begin
					if (ack)
					begin
						req   <= 1'b0;
						state <= wait_busy_low;
					end
				end
				wait_busy_low:
				begin
					// busy came up with ack, so low here means the engine finished
					if (!busy)
					begin
						done  <= 1'b1;
						state <= wait_trigger;
					end
				end
				default:
				begin
					state <= wait_trigger;
				end
			endcase
		end
	end

endmodule

// ==== common/dp_reconfig_pkg.sv ====
package dp_reconfig_pkg;

	// ********************************************************
	// channel numbering and engine timing
	// ********************************************************

	// two request channels share the one reconfiguration engine
	localparam int num_channels = 2;
	localparam int chan_id_w = $clog2(num_channels);

	// channel 0 carries link rate requests, channel 1 drive level requests
	localparam logic [chan_id_w-1:0] chan_rate = 1'b0;
	localparam logic [chan_id_w-1:0] chan_drive = 1'b1;

	// engine busy time per kind of operation, in clk cycles
	localparam int rate_busy_cycles = 8;
	localparam int drive_busy_cycles = 4;
	localparam int busy_cnt_w = $clog2(rate_busy_cycles);

	// DisplayPort link rate codes
	localparam logic [1:0] rate_rbr = 2'd0;
	localparam logic [1:0] rate_hbr = 2'd1;
	localparam logic [1:0] rate_hbr2 = 2'd2;
	localparam logic [1:0] rate_hbr3 = 2'd3;

	// ********************************************************
	// payload types
	// ********************************************************

	typedef struct packed {
		logic [1:0] rate;
		logic [2:0] lanes;
	} link_rate_t;

	typedef struct packed {
		logic [1:0] swing;
		logic [1:0] preemph;
	} drive_level_t;

	// the data field fits link_rate_t, drive_level_t rides zero-extended
	localparam int reconfig_data_w = $bits(link_rate_t);

	typedef struct packed {
		logic [chan_id_w-1:0] chan_id;
		logic [reconfig_data_w-1:0] data;
	} reconfig_word_t;

	// link state out of reset is RBR on a single lane
	localparam link_rate_t rate_reset = '{rate: rate_rbr, lanes: 3'd1};

endpackage
